//--- source/stbuf_pkg.sv
// Store buffer shared definitions

package stbuf_pkg;

  // ------------------------------
  // Address and block geometry
  // ------------------------------
  localparam int PADDR_W      = 32;
  localparam int ST_BUF_BYTES = 16;
  localparam int ST_BUF_W     = ST_BUF_BYTES * 8;
  localparam int BLK_LSB      = $clog2(ST_BUF_BYTES);

  // ------------------------------
  // Cache write port geometry
  // ------------------------------
  localparam int DCACHE_BYTES = 32;
  localparam int DCACHE_W     = DCACHE_BYTES * 8;
  localparam int LINE_SPLIT   = DCACHE_BYTES / ST_BUF_BYTES;
  localparam int LINE_SEL_W   = $clog2(LINE_SPLIT);
  localparam int LINE_LSB     = $clog2(DCACHE_BYTES);

  // Buffer depth
  localparam int ENTRY_NUM    = 4;

  // Load forwarding works on one 8-byte half of a block
  localparam int FWD_BYTES    = 8;
  localparam int FWD_W        = FWD_BYTES * 8;
  localparam int FWD_LSB      = $clog2(FWD_BYTES);

  // ------------------------------
  // Store handshake answer
  // ------------------------------
  typedef enum logic [1:0] {
    ALLOC = 2'd0,
    MERGE = 2'd1,
    FULL  = 2'd2
  } stbuf_resp_t;

  // One buffered block
  typedef struct packed {
    logic                    valid;
    logic [PADDR_W-1:0]      paddr;
    logic [ST_BUF_BYTES-1:0] strb;
    logic [ST_BUF_W-1:0]     data;
  } stbuf_entry_t;

endpackage

//--- source/stbuf_alloc_decode.sv
// Store allocate and merge decision

module stbuf_alloc_decode
  import stbuf_pkg::*;
(
  input  logic               i_st_valid,
  input  logic [PADDR_W-1:0] i_st_paddr,
  input  stbuf_entry_t       i_entries [ENTRY_NUM],
  input  logic [ENTRY_NUM-1:0] i_head_oh,
  output stbuf_resp_t        o_st_resp,
  output logic               o_alloc,
  output logic [ENTRY_NUM-1:0] o_merge_oh
);

  logic [ENTRY_NUM-1:0] w_valids;
  logic [ENTRY_NUM-1:0] w_match;
  logic [ENTRY_NUM-1:0] w_tail_match;
  logic                 w_head_match;
  logic                 w_full;

  // ------------------------------
  // Block address compare
  // ------------------------------
  generate
    for (genvar e = 0; e < ENTRY_NUM; e++) begin : g_match
      assign w_valids[e] = i_entries[e].valid;
      assign w_match[e]  = i_entries[e].valid &
                           (i_entries[e].paddr[PADDR_W-1:BLK_LSB] ==
                            i_st_paddr[PADDR_W-1:BLK_LSB]);
    end
  endgenerate

  // Head is already offered to the cache, so it cannot take new bytes
  assign w_head_match = |(w_match & i_head_oh);
  assign w_tail_match = w_match & ~i_head_oh;

  // Entries fill in order, so all valids set means no free slot
  assign w_full = &w_valids;

  // ------------------------------
  // Response rule
  // ------------------------------
  always_comb begin
    if (w_head_match) begin
      o_st_resp = FULL;
    end else if (|w_tail_match) begin
      o_st_resp = MERGE;
    end else if (!w_full) begin
      o_st_resp = ALLOC;
    end else begin
      o_st_resp = FULL;
    end
  end

  // Actions only fire for a real store
  assign o_alloc    = i_st_valid & (o_st_resp == ALLOC);
  assign o_merge_oh = (o_st_resp == MERGE) ? (w_tail_match & {ENTRY_NUM{i_st_valid}})
                                           : '0;

endmodule

//--- source/stbuf_entry_array.sv
// Store buffer entry storage

module stbuf_entry_array
  import stbuf_pkg::*;
(
  input  logic                    i_clk,
  input  logic                    i_reset_n,

  // Store write side
  input  logic                    i_alloc,
  input  logic [ENTRY_NUM-1:0]    i_merge_oh,
  input  logic [PADDR_W-1:0]      i_st_paddr,
  input  logic [ST_BUF_BYTES-1:0] i_st_strb,
  input  logic [ST_BUF_W-1:0]     i_st_data,

  // Drain side
  input  logic                    i_retire,

  output stbuf_entry_t            o_entries [ENTRY_NUM],
  output logic [ENTRY_NUM-1:0]    o_head_oh,
  output logic                    o_empty
);

  logic [ENTRY_NUM-1:0]    r_valid;
  logic [ENTRY_NUM-1:0]    r_in_ptr_oh;
  logic [ENTRY_NUM-1:0]    r_out_ptr_oh;

  logic [PADDR_W-1:0]      r_paddr [ENTRY_NUM];
  logic [ST_BUF_BYTES-1:0] r_strb  [ENTRY_NUM];
  logic [ST_BUF_W-1:0]     r_data  [ENTRY_NUM];

  // ------------------------------
  // In and out pointers
  // ------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_in_ptr_oh  <= {{(ENTRY_NUM-1){1'b0}}, 1'b1};
      r_out_ptr_oh <= {{(ENTRY_NUM-1){1'b0}}, 1'b1};
    end else begin
      if (i_alloc) begin
        r_in_ptr_oh <= {r_in_ptr_oh[ENTRY_NUM-2:0], r_in_ptr_oh[ENTRY_NUM-1]};
      end
      if (i_retire) begin
        r_out_ptr_oh <= {r_out_ptr_oh[ENTRY_NUM-2:0], r_out_ptr_oh[ENTRY_NUM-1]};
      end
    end
  end

  // ------------------------------
  // Entry valid bits
  // ------------------------------
  // Alloc targets a free slot and retire the head, never the same entry
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= '0;
    end else begin
      for (int e = 0; e < ENTRY_NUM; e++) begin
        if (i_alloc && r_in_ptr_oh[e]) begin
          r_valid[e] <= 1'b1;
        end else if (i_retire && r_out_ptr_oh[e]) begin
          r_valid[e] <= 1'b0;
        end
      end
    end
  end

  // ------------------------------
  // Entry payload
  // ------------------------------
  always_ff @(posedge i_clk) begin
    for (int e = 0; e < ENTRY_NUM; e++) begin
      if (i_alloc && r_in_ptr_oh[e]) begin
        r_paddr[e] <= i_st_paddr;
        r_strb[e]  <= i_st_strb;
        r_data[e]  <= i_st_data;
      end else if (i_merge_oh[e]) begin
        // Newer bytes win where the store strobe is set
        r_strb[e] <= r_strb[e] | i_st_strb;
        for (int b = 0; b < ST_BUF_BYTES; b++) begin
          if (i_st_strb[b]) begin
            r_data[e][b*8 +: 8] <= i_st_data[b*8 +: 8];
          end
        end
      end
    end
  end

  // Entry records seen by decode, drain and forward
  generate
    for (genvar e = 0; e < ENTRY_NUM; e++) begin : g_out
      assign o_entries[e].valid = r_valid[e];
      assign o_entries[e].paddr = r_paddr[e];
      assign o_entries[e].strb  = r_strb[e];
      assign o_entries[e].data  = r_data[e];
    end
  endgenerate

  assign o_head_oh = r_out_ptr_oh;
  assign o_empty   = ~|r_valid;

endmodule

//--- source/stbuf_drain.sv
// Cache line write formatter

module stbuf_drain
  import stbuf_pkg::*;
(
  input  stbuf_entry_t            i_entries [ENTRY_NUM],
  input  logic [ENTRY_NUM-1:0]    i_head_oh,
  input  logic                    i_wr_ready,
  output logic                    o_wr_valid,
  output logic [PADDR_W-1:0]      o_wr_paddr,
  output logic [DCACHE_BYTES-1:0] o_wr_be,
  output logic [DCACHE_W-1:0]     o_wr_data,
  output logic                    o_retire
);

  stbuf_entry_t          w_head;
  logic [LINE_SEL_W-1:0] w_half;

  // ------------------------------
  // Head entry select
  // ------------------------------
  always_comb begin
    w_head = '0;
    for (int e = 0; e < ENTRY_NUM; e++) begin
      if (i_head_oh[e]) begin
        w_head = stbuf_entry_t'(w_head | i_entries[e]);
      end
    end
  end

  // Which 16-byte slot of the line this block lives in
  assign w_half = w_head.paddr[BLK_LSB +: LINE_SEL_W];

  // ------------------------------
  // Line placement
  // ------------------------------
  assign o_wr_valid = w_head.valid;
  assign o_wr_paddr = {w_head.paddr[PADDR_W-1:LINE_LSB], {LINE_LSB{1'b0}}};

  always_comb begin
    o_wr_be = '0;
    for (int h = 0; h < LINE_SPLIT; h++) begin
      if (int'(w_half) == h) begin
        o_wr_be[h*ST_BUF_BYTES +: ST_BUF_BYTES] = w_head.strb;
      end
    end
  end

  // Same block copied in every slot, enables pick the real one
  assign o_wr_data = {LINE_SPLIT{w_head.data}};

  // Head leaves on the accepted write
  assign o_retire = o_wr_valid & i_wr_ready;

endmodule

//--- source/stbuf_fwd.sv
// Store to load forwarding lookup

module stbuf_fwd
  import stbuf_pkg::*;
(
  input  logic                 i_fwd_valid,
  input  logic [PADDR_W-1:0]   i_fwd_paddr,
  input  stbuf_entry_t         i_entries [ENTRY_NUM],
  output logic                 o_fwd_hit,
  output logic [FWD_BYTES-1:0] o_fwd_strb,
  output logic [FWD_W-1:0]     o_fwd_data
);

  logic [ENTRY_NUM-1:0] w_hit_oh;
  stbuf_entry_t         w_sel;
  logic                 w_upper;

  // ------------------------------
  // Block match
  // ------------------------------
  // One entry per block at most, so the hit vector is one-hot
  generate
    for (genvar e = 0; e < ENTRY_NUM; e++) begin : g_hit
      assign w_hit_oh[e] = i_fwd_valid & i_entries[e].valid &
                           (i_entries[e].paddr[PADDR_W-1:BLK_LSB] ==
                            i_fwd_paddr[PADDR_W-1:BLK_LSB]);
    end
  endgenerate

  // Zero when nothing hits
  always_comb begin
    w_sel = '0;
    for (int e = 0; e < ENTRY_NUM; e++) begin
      if (w_hit_oh[e]) begin
        w_sel = stbuf_entry_t'(w_sel | i_entries[e]);
      end
    end
  end

  // ------------------------------
  // Half select
  // ------------------------------
  assign w_upper = i_fwd_paddr[FWD_LSB];

  assign o_fwd_hit  = |w_hit_oh;
  assign o_fwd_strb = w_upper ? w_sel.strb[FWD_BYTES +: FWD_BYTES]
                              : w_sel.strb[FWD_BYTES-1:0];
  assign o_fwd_data = w_upper ? w_sel.data[FWD_W +: FWD_W]
                              : w_sel.data[FWD_W-1:0];

endmodule

//--- source/stbuf_top.sv
// Committed store buffer top

module stbuf_top
  import stbuf_pkg::*;
(
  input  logic                    i_clk,
  input  logic                    i_reset_n,

  // Committed store request
  input  logic                    i_st_valid,
  input  logic [PADDR_W-1:0]      i_st_paddr,
  input  logic [ST_BUF_BYTES-1:0] i_st_strb,
  input  logic [ST_BUF_W-1:0]     i_st_data,
  output stbuf_resp_t             o_st_resp,

  // Cache write port
  output logic                    o_wr_valid,
  output logic [PADDR_W-1:0]      o_wr_paddr,
  output logic [DCACHE_BYTES-1:0] o_wr_be,
  output logic [DCACHE_W-1:0]     o_wr_data,
  input  logic                    i_wr_ready,

  // Load forwarding lookup
  input  logic                    i_fwd_valid,
  input  logic [PADDR_W-1:0]      i_fwd_paddr,
  output logic                    o_fwd_hit,
  output logic [FWD_BYTES-1:0]    o_fwd_strb,
  output logic [FWD_W-1:0]        o_fwd_data,

  output logic                    o_empty
);

  stbuf_entry_t         w_entries [ENTRY_NUM];
  logic [ENTRY_NUM-1:0] w_head_oh;
  logic                 w_alloc;
  logic [ENTRY_NUM-1:0] w_merge_oh;
  logic                 w_retire;

  // ------------------------------
  // Decode
  // ------------------------------
  stbuf_alloc_decode u_decode (
    .i_st_valid (i_st_valid),
    .i_st_paddr (i_st_paddr),
    .i_entries  (w_entries),
    .i_head_oh  (w_head_oh),
    .o_st_resp  (o_st_resp),
    .o_alloc    (w_alloc),
    .o_merge_oh (w_merge_oh)
  );

  // ------------------------------
  // Entry array
  // ------------------------------
  stbuf_entry_array u_array (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_alloc    (w_alloc),
    .i_merge_oh (w_merge_oh),
    .i_st_paddr (i_st_paddr),
    .i_st_strb  (i_st_strb),
    .i_st_data  (i_st_data),
    .i_retire   (w_retire),
    .o_entries  (w_entries),
    .o_head_oh  (w_head_oh),
    .o_empty    (o_empty)
  );

  // ------------------------------
  // Results
  // ------------------------------
  stbuf_drain u_drain (
    .i_entries  (w_entries),
    .i_head_oh  (w_head_oh),
    .i_wr_ready (i_wr_ready),
    .o_wr_valid (o_wr_valid),
    .o_wr_paddr (o_wr_paddr),
    .o_wr_be    (o_wr_be),
    .o_wr_data  (o_wr_data),
    .o_retire   (w_retire)
  );

  stbuf_fwd u_fwd (
    .i_fwd_valid (i_fwd_valid),
    .i_fwd_paddr (i_fwd_paddr),
    .i_entries   (w_entries),
    .o_fwd_hit   (o_fwd_hit),
    .o_fwd_strb  (o_fwd_strb),
    .o_fwd_data  (o_fwd_data)
  );

endmodule

//--- testbench/tb_clock_gen.sv
// Testbench clock and reset

module tb_clock_gen (
  output logic o_clk,
  output logic o_reset_n
);

  localparam int HALF_PERIOD = 20;

  initial begin
    o_clk = 1'b0;
    forever #HALF_PERIOD o_clk = ~o_clk;
  end

  // Reset held for 10 cycles, released away from the rising edge
  initial begin
    o_reset_n = 1'b0;
    repeat (10) @(posedge o_clk);
    @(negedge o_clk);
    o_reset_n = 1'b1;
  end

endmodule

//--- testbench/stbuf_tb.sv
// Store buffer testbench

module stbuf_tb
  import stbuf_pkg::*;
();

  logic                    clk;
  logic                    rst_n;
  logic                    st_valid;
  logic [PADDR_W-1:0]      st_paddr;
  logic [ST_BUF_BYTES-1:0] st_strb;
  logic [ST_BUF_W-1:0]     st_data;
  logic [1:0]              st_resp;
  logic                    wr_valid;
  logic [PADDR_W-1:0]      wr_paddr;
  logic [DCACHE_BYTES-1:0] wr_be;
  logic [DCACHE_W-1:0]     wr_data;
  logic                    wr_ready;
  logic                    fwd_valid;
  logic [PADDR_W-1:0]      fwd_paddr;
  logic                    fwd_hit;
  logic [FWD_BYTES-1:0]    fwd_strb;
  logic [FWD_W-1:0]        fwd_data;
  logic                    empty;

  int                      fd;
  int                      code;
  int                      n_pass;
  int                      n_fail;
  logic                    ready_level;
  logic                    timed_out;
  logic [63:0]             cmd;
  logic [8*160-1:0]        rest;

  tb_clock_gen u_clk (
    .o_clk     (clk),
    .o_reset_n (rst_n)
  );

  stbuf_top dut_i (
    .i_clk       (clk),
    .i_reset_n   (rst_n),
    .i_st_valid  (st_valid),
    .i_st_paddr  (st_paddr),
    .i_st_strb   (st_strb),
    .i_st_data   (st_data),
    .o_st_resp   (st_resp),
    .o_wr_valid  (wr_valid),
    .o_wr_paddr  (wr_paddr),
    .o_wr_be     (wr_be),
    .o_wr_data   (wr_data),
    .i_wr_ready  (wr_ready),
    .i_fwd_valid (fwd_valid),
    .i_fwd_paddr (fwd_paddr),
    .o_fwd_hit   (fwd_hit),
    .o_fwd_strb  (fwd_strb),
    .o_fwd_data  (fwd_data),
    .o_empty     (empty)
  );

  // ------------------------------
  // Result bookkeeping
  // ------------------------------
  task automatic count_pass(input string msg);
    n_pass++;
    $display("[PASS] %s", msg);
  endtask

  task automatic report_mismatch(input string msg);
    n_fail++;
    $display("[FAIL] %0t: %s", $time, msg);
  endtask

  // Field count of the last golden line read
  task automatic expect_fields(input int want, input string kind);
    if (code != want) begin
      $display("Golden file %s line holds %0d fields instead of %0d", kind, code, want);
      n_fail++;
    end
  endtask

  // Called right after a falling edge
  task automatic drive_idle();
    st_valid  = 1'b0;
    fwd_valid = 1'b0;
    wr_ready  = ready_level;
  endtask

  // ------------------------------
  // Golden file commands
  // ------------------------------
  task automatic apply_store();
    logic [PADDR_W-1:0]      a;
    logic [ST_BUF_BYTES-1:0] s;
    logic [ST_BUF_W-1:0]     d;
    logic [1:0]              r;
    code = $fscanf(fd, "%h %h %h %h", a, s, d, r);
    expect_fields(4, "STORE");
    @(negedge clk);
    drive_idle();
    st_valid = 1'b1;
    st_paddr = a;
    st_strb  = s;
    st_data  = d;
    #10;
    if (st_resp !== r) begin
      report_mismatch($sformatf("STORE %h resp %0d, expected %0d", a, st_resp, r));
    end else begin
      count_pass($sformatf("STORE %h resp %0d", a, r));
    end
  endtask

  task automatic lookup_fwd();
    logic [PADDR_W-1:0]   a;
    logic                 h;
    logic [FWD_BYTES-1:0] s;
    logic [FWD_W-1:0]     d;
    code = $fscanf(fd, "%h %h %h %h", a, h, s, d);
    expect_fields(4, "FWD");
    @(negedge clk);
    drive_idle();
    fwd_valid = 1'b1;
    fwd_paddr = a;
    #10;
    if (fwd_hit !== h || fwd_strb !== s || fwd_data !== d) begin
      report_mismatch($sformatf("FWD %h got %0d %h %h, expected %0d %h %h",
                                a, fwd_hit, fwd_strb, fwd_data, h, s, d));
    end else begin
      count_pass($sformatf("FWD %h hit %0d strb %h", a, h, s));
    end
  endtask

  // Waits for the valid and ready edge
  task automatic await_write();
    logic [PADDR_W-1:0]      a;
    logic [DCACHE_BYTES-1:0] be;
    logic [DCACHE_W-1:0]     d;
    logic                    seen;
    int                      n;
    code = $fscanf(fd, "%h %h %h", a, be, d);
    expect_fields(3, "WRITE");
    seen = 1'b0;
    n = 0;
    while (!seen && n < 200) begin
      @(negedge clk);
      drive_idle();
      #10;
      if (wr_valid && wr_ready) begin
        seen = 1'b1;
        if (wr_paddr !== a || wr_be !== be || wr_data !== d) begin
          report_mismatch($sformatf("WRITE got %h be %h data %h, expected %h be %h data %h",
                                    wr_paddr, wr_be, wr_data, a, be, d));
        end else begin
          count_pass($sformatf("WRITE %h be %h", a, be));
        end
      end
      n++;
    end
    if (!seen) begin
      $display("Timed out after 200 cycles waiting for the cache write to %h", a);
      timed_out = 1'b1;
    end
  endtask

  task automatic check_status();
    logic e;
    logic v;
    code = $fscanf(fd, "%h %h", e, v);
    expect_fields(2, "STATUS");
    @(negedge clk);
    drive_idle();
    #10;
    if (empty !== e || wr_valid !== v) begin
      report_mismatch($sformatf("STATUS empty %0d wr_valid %0d, expected %0d %0d",
                                empty, wr_valid, e, v));
    end else begin
      count_pass($sformatf("STATUS empty %0d wr_valid %0d", e, v));
    end
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    int n;
    n_pass      = 0;
    n_fail      = 0;
    timed_out   = 1'b0;
    ready_level = 1'b0;
    st_valid    = 1'b0;
    st_paddr    = '0;
    st_strb     = '0;
    st_data     = '0;
    wr_ready    = 1'b0;
    fwd_valid   = 1'b0;
    fwd_paddr   = '0;
    fd = $fopen("testbench/stbuf_golden.txt", "r");
    if (fd == 0) begin
      $display("Could not open the golden file testbench/stbuf_golden.txt");
      n_fail++;
    end else begin
      n = 0;
      while (rst_n !== 1'b1 && n < 50) begin
        @(posedge clk);
        n++;
      end
      if (rst_n !== 1'b1) begin
        $display("Reset was never released");
        timed_out = 1'b1;
      end
      while (!timed_out && $fscanf(fd, "%s", cmd) == 1) begin
        if (cmd == 64'("#")) begin
          code = $fgets(rest, fd);
        end else if (cmd == 64'("STORE")) begin
          apply_store();
        end else if (cmd == 64'("READY")) begin
          // Takes effect at the next falling edge
          code = $fscanf(fd, "%h", ready_level);
          expect_fields(1, "READY");
        end else if (cmd == 64'("FWD")) begin
          lookup_fwd();
        end else if (cmd == 64'("WRITE")) begin
          await_write();
        end else if (cmd == 64'("STATUS")) begin
          check_status();
        end else begin
          $display("Unknown command in the golden file");
          n_fail++;
        end
      end
      $fclose(fd);
    end
    $display("tests run: %0d, passed: %0d, failed: %0d", n_pass + n_fail, n_pass, n_fail);
    if (n_fail == 0 && !timed_out) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- tb.f
source/stbuf_pkg.sv
source/stbuf_alloc_decode.sv
source/stbuf_entry_array.sv
source/stbuf_drain.sv
source/stbuf_fwd.sv
source/stbuf_top.sv
testbench/tb_clock_gen.sv
testbench/stbuf_tb.sv

//--- Makefile
.PHONY: all run lint clean

all: run

obj_dir/Vstbuf_tb: tb.f $(wildcard source/*.sv) $(wildcard testbench/*.sv)
	verilator --binary -j 0 -f tb.f --top-module stbuf_tb -o Vstbuf_tb

run: obj_dir/Vstbuf_tb
	@out="$$(./obj_dir/Vstbuf_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "all tests passed"

lint:
	verilator --lint-only --timing -f tb.f --top-module stbuf_tb

clean:
	rm -rf obj_dir

//--- testbench/stbuf_golden.txt
# STORE addr strb data resp (0 ALLOC, 1 MERGE, 2 FULL) | READY level | STATUS empty wr_valid
# FWD addr hit strb data | WRITE paddr be data | all fields in hex
STATUS 1 0
READY 0
STORE 00001000 ffff 0f0e0d0c0b0a09080706050403020100 0
STORE 00001010 00ff 1f1e1d1c1b1a19181716151413121110 0
STORE 00002030 0f0f 2f2e2d2c2b2a29282726252423222120 0
STORE 00003008 f000 3f3e3d3c3b3a39383736353433323130 0
STORE 00004000 ffff 4f4e4d4c4b4a49484746454443424140 2
STATUS 0 1
STORE 00001018 ff00 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 1
FWD 00001010 1 ff 1716151413121110
FWD 0000101c 1 ff afaeadacabaaa9a8
STORE 00001004 000f 5f5e5d5c5b5a59585756555453525150 2
STORE 00002034 00f0 cfcecdcccbcac9c8c7c6c5c4c3c2c1c0 1
FWD 00002030 1 ff c7c6c5c423222120
FWD 0000300c 1 f0 3f3e3d3c3b3a3938
FWD 00003000 1 00 3736353433323130
FWD 00005008 0 00 0000000000000000
READY 1
WRITE 00001000 0000ffff 0f0e0d0c0b0a090807060504030201000f0e0d0c0b0a09080706050403020100
WRITE 00001000 ffff0000 afaeadacabaaa9a81716151413121110afaeadacabaaa9a81716151413121110
WRITE 00002020 0fff0000 2f2e2d2c2b2a2928c7c6c5c4232221202f2e2d2c2b2a2928c7c6c5c423222120
WRITE 00003000 0000f000 3f3e3d3c3b3a393837363534333231303f3e3d3c3b3a39383736353433323130
STATUS 1 0
STORE 00001000 000f 6f6e6d6c6b6a69686766656463626160 0
WRITE 00001000 0000000f 6f6e6d6c6b6a696867666564636261606f6e6d6c6b6a69686766656463626160
STATUS 1 0
